// ==== sim.f ====
+incdir+rtl
rtl/rv_core_pkg.sv
rtl/rf_if.sv
rtl/reg_file.sv
rtl/inst_decode.sv
rtl/alu.sv
rtl/data_mem.sv
rtl/rv_core_top.sv
bench/core_checker.sv
bench/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_top -f sim.f > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_top > sim.log 2>&1 ; cat sim.log
grep -qx 'TESTS PASSED' sim.log && echo "simulation ok" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== bench/tb_top.sv ====
`default_nettype none
`include "rv_core_config.svh"

module tb_top import rv_core_pkg::*; ();

    localparam int NUM_TESTS    = 6;
    localparam int TEST_LEN     = 200;
    localparam int SETUP_LEN    = 211;  // instructions in seed_registers
    localparam int RESET_CYCLES = 5;
    localparam int CLK_PERIOD   = 4;
    localparam int WATCHDOG     =
        (2 * (NUM_TESTS * TEST_LEN + SETUP_LEN) + RESET_CYCLES + 20) * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_valid;
    logic [31:0]           inst;
    wire                   retire_valid;
    wire                   retire_wen;
    wire  [`RV_REG_AW-1:0] retire_rd;
    wire  [`RV_XLEN-1:0]   retire_data;
    wire                   retire_illegal;
    int                    errors;
    int                    checks;
    int                    dirty_tests;
    logic [31:0]           lfsr;

    rv_core_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .retire_valid   (retire_valid),
        .retire_wen     (retire_wen),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal)
    );

    core_checker check0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .retire_valid   (retire_valid),
        .retire_wen     (retire_wen),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal),
        .errors         (errors),
        .checks         (checks)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    function automatic logic [31:0] rtype_inst();
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = 3'(take_bits(3));
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && take_bits(1) == 1) ? 7'h20 : 7'h00;
        return r_type(f7, 5'(take_bits(5)), 5'(take_bits(5)), f3, 5'(take_bits(5)), OP);
    endfunction

    function automatic logic [31:0] itype_inst();
        logic [2:0] f3;
        case (take_bits(2))
            0: f3 = 3'b000;  // addi
            1: f3 = 3'b100;
            2: f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        return i_type(12'(take_bits(12)), 5'(take_bits(5)), f3, 5'(take_bits(5)), OP_IMM);
    endfunction

    function automatic logic [31:0] word_inst();
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        rd  = 5'(take_bits(5));
        rs1 = 5'(take_bits(5));
        rs2 = 5'(take_bits(5));
        case (take_bits(2))
            0: return r_type(7'h00, rs2, rs1, 3'b000, rd, OP_32);
            1: return r_type(7'h20, rs2, rs1, 3'b000, rd, OP_32);
            default: return i_type(12'(take_bits(12)), rs1, 3'b000, rd, OP_IMM_32);
        endcase
    endfunction

    // x31 holds the base address, moved now and then by an addi
    function automatic logic [31:0] mem_inst();
        logic [1:0]  kind;
        logic [4:0]  reg_d;
        logic [11:0] off;
        if (take_bits(2) == 0)
            return i_type({3'b000, 6'(take_bits(6)), 3'b000}, 5'd0, 3'b000, 5'd31, OP_IMM);
        kind  = 2'(take_bits(2));
        reg_d = 5'(take_bits(5));
        if (reg_d == 5'd31)
            reg_d = 5'd30;
        off = kind[0] ? {6'b0, 3'(take_bits(3)), 3'b000} : {6'b0, 4'(take_bits(4)), 2'b00};
        if (kind[1])
            return s_type(off, reg_d, 5'd31, kind[0] ? 3'b011 : 3'b010, STORE);
        return i_type(off, 5'd31, kind[0] ? 3'b011 : 3'b010, reg_d, LOAD);
    endfunction

    function automatic logic [31:0] x0_inst();
        logic [31:0] w;
        w = (take_bits(1) == 1) ? rtype_inst() : itype_inst();
        if (take_bits(1) == 1)
            w[11:7] = 5'd0;   // write x0
        else
            w[19:15] = 5'd0;  // read x0
        return w;
    endfunction

    function automatic logic [31:0] illegal_inst();
        logic [2:0]  f3;
        logic [11:0] off;
        case (take_bits(2))
            0: return take_bits(32);  // mostly unknown opcodes
            1: begin
                f3 = 3'(take_bits(2));
                if (f3 == 3'd0)
                    f3 = 3'd5;
                return i_type(12'(take_bits(12)), 5'(take_bits(5)), f3, 5'(take_bits(5)), OP_IMM);
            end
            2: begin
                off = {2'b00, 7'(take_bits(7)), 3'b000} | 12'(take_bits(2) + 1);
                if (take_bits(1) == 1)
                    return s_type(off, 5'(take_bits(5)), 5'd31, {2'b01, 1'(take_bits(1))}, STORE);
                return i_type(off, 5'd31, {2'b01, 1'(take_bits(1))}, 5'(take_bits(5)), LOAD);
            end
            default: return mem_inst();  // legal reads see untouched state
        endcase
    endfunction

    task automatic issue(input logic [31:0] word);
        if (take_bits(3) == 0) begin
            inst_valid <= 1'b0;
            @(posedge clk);
        end
        inst_valid <= 1'b1;
        inst       <= word;
        @(posedge clk);
    endtask

    // wide random values: addi, then shift by 16 and xori three times
    task automatic seed_registers();
        issue(i_type(12'd16, 5'd0, 3'b000, 5'd31, OP_IMM));
        for (int r = 1; r < 31; r++) begin
            issue(i_type(12'(take_bits(12)), 5'd0, 3'b000, 5'(r), OP_IMM));
            repeat (3) begin
                issue(r_type(7'h00, 5'd31, 5'(r), 3'b001, 5'(r), OP));
                issue(i_type(12'(take_bits(12)), 5'(r), 3'b100, 5'(r), OP_IMM));
            end
        end
    endtask

    task automatic run_test(input int num, input string name);
        int          err_before;
        logic [31:0] w;
        err_before = errors;
        for (int k = 0; k < TEST_LEN; k++) begin
            case (num)
                1: w = rtype_inst();
                2: w = itype_inst();
                3: w = word_inst();
                4: w = mem_inst();
                5: w = x0_inst();
                default: w = illegal_inst();
            endcase
            issue(w);
        end
        inst_valid <= 1'b0;
        repeat (2) @(posedge clk);  // let the last retirement be compared
        $display("test %0d %s: %0d instructions, %0d mismatches",
                 num, name, TEST_LEN, errors - err_before);
        if (errors != err_before)
            dirty_tests++;
    endtask

    initial begin
        #(WATCHDOG);
        $display("run timed out at %0t before the tests finished", $time);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        lfsr        = 32'ha269dc3d;
        dirty_tests = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        seed_registers();
        run_test(1, "r-type");
        run_test(2, "i-type");
        run_test(3, "word ops");
        run_test(4, "load/store");
        run_test(5, "x0");
        run_test(6, "illegal");
        $display("%0d tests, %0d with mismatches, %0d retirements checked, %0d errors",
                 NUM_TESTS, dirty_tests, checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/core_checker.sv ====
`default_nettype none
`include "rv_core_config.svh"

module core_checker (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   inst_valid,
    input  wire  [31:0]           inst,
    input  wire                   retire_valid,
    input  wire                   retire_wen,
    input  wire  [`RV_REG_AW-1:0] retire_rd,
    input  wire  [`RV_XLEN-1:0]   retire_data,
    input  wire                   retire_illegal,
    output int                    errors,
    output int                    checks
);

    logic [`RV_XLEN-1:0]   regs [0:`RV_NUM_REGS-1];   // regs[0] is never written
    logic [`RV_XLEN-1:0]   mem  [0:`RV_MEM_WORDS-1];
    logic                  exp_valid;
    logic                  exp_wen;
    logic                  exp_illegal;
    logic [`RV_REG_AW-1:0] exp_rd;
    logic [`RV_XLEN-1:0]   exp_data;
    logic [31:0]           exp_inst;

    function automatic logic [`RV_XLEN-1:0] sext_word(input logic [31:0] v);
        return {{(`RV_XLEN-32){v[31]}}, v};
    endfunction

    task automatic report_mismatch(input string field, input logic [`RV_XLEN-1:0] got,
                                   input logic [`RV_XLEN-1:0] want);
        $display("Fail %0t: %s is %h, expected %h (inst %h)", $time, field, got, want, exp_inst);
        errors++;
    endtask

    task automatic compare_retire();
        if (exp_valid && retire_valid !== 1'b1) begin
            $display("at %0t an accepted instruction %h did not retire", $time, exp_inst);
            errors++;
        end else if (!exp_valid && retire_valid !== 1'b0) begin
            $display("at %0t the core retired with no instruction accepted", $time);
            errors++;
        end else if (exp_valid) begin
            checks++;
            if (retire_illegal !== exp_illegal)
                report_mismatch("retire_illegal", 64'(retire_illegal), 64'(exp_illegal));
            if (retire_wen !== exp_wen)
                report_mismatch("retire_wen", 64'(retire_wen), 64'(exp_wen));
            if (exp_wen && retire_rd !== exp_rd)
                report_mismatch("retire_rd", 64'(retire_rd), 64'(exp_rd));
            if (exp_wen && retire_data !== exp_data)
                report_mismatch("retire_data", retire_data, exp_data);
        end
    endtask

    // architectural effect of one accepted instruction
    task automatic model_step(input logic [31:0] w);
        logic [6:0]            opc;
        logic [2:0]            f3;
        logic [6:0]            f7;
        logic [`RV_XLEN-1:0]   a;
        logic [`RV_XLEN-1:0]   b;
        logic [`RV_XLEN-1:0]   imm_i;
        logic [`RV_XLEN-1:0]   imm_s;
        logic [`RV_XLEN-1:0]   addr;
        logic [`RV_MEM_AW-1:0] idx;
        logic [`RV_XLEN-1:0]   res;
        logic                  ok;
        logic                  wr;
        opc   = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        a     = regs[w[19:15]];
        b     = regs[w[24:20]];
        imm_i = {{(`RV_XLEN-12){w[31]}}, w[31:20]};
        imm_s = {{(`RV_XLEN-12){w[31]}}, w[31:25], w[11:7]};
        addr  = a + ((opc == 7'b0100011) ? imm_s : imm_i);
        idx   = addr[`RV_MEM_AW+2:3];
        res   = '0;
        ok    = 1'b1;
        wr    = 1'b1;
        case (opc)
            7'b0110011: begin
                if (f7 == 7'h20 && f3 == 3'd0)
                    res = a - b;
                else if (f7 == 7'h20 && f3 == 3'd5)
                    res = $signed(a) >>> b[5:0];
                else if (f7 != 7'h00)
                    ok = 1'b0;
                else begin
                    case (f3)
                        3'd0: res = a + b;
                        3'd1: res = a << b[5:0];
                        3'd2: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
                        3'd3: res = (a < b) ? 64'd1 : 64'd0;
                        3'd4: res = a ^ b;
                        3'd5: res = a >> b[5:0];
                        3'd6: res = a | b;
                        default: res = a & b;
                    endcase
                end
            end
            7'b0010011: begin
                case (f3)
                    3'd0: res = a + imm_i;
                    3'd4: res = a ^ imm_i;
                    3'd6: res = a | imm_i;
                    3'd7: res = a & imm_i;
                    default: ok = 1'b0;
                endcase
            end
            7'b0111011: begin
                if (f3 == 3'd0 && f7 == 7'h00)
                    res = sext_word(32'(a + b));
                else if (f3 == 3'd0 && f7 == 7'h20)
                    res = sext_word(32'(a - b));
                else
                    ok = 1'b0;
            end
            7'b0011011: begin
                if (f3 == 3'd0)
                    res = sext_word(32'(a + imm_i));
                else
                    ok = 1'b0;
            end
            7'b0000011: begin
                if (f3 == 3'd3 && addr[2:0] == 3'd0)
                    res = mem[idx];
                else if (f3 == 3'd2 && addr[1:0] == 2'd0)
                    res = sext_word(addr[2] ? mem[idx][63:32] : mem[idx][31:0]);
                else
                    ok = 1'b0;
            end
            7'b0100011: begin
                wr = 1'b0;
                if (f3 == 3'd3 && addr[2:0] == 3'd0)
                    mem[idx] = b;
                else if (f3 == 3'd2 && addr[1:0] == 2'd0 && addr[2])
                    mem[idx][63:32] = b[31:0];  // other half kept
                else if (f3 == 3'd2 && addr[1:0] == 2'd0)
                    mem[idx][31:0] = b[31:0];
                else
                    ok = 1'b0;
            end
            default: ok = 1'b0;
        endcase
        exp_valid   = 1'b1;
        exp_illegal = !ok;
        exp_wen     = ok && wr;
        exp_rd      = w[11:7];
        exp_data    = res;
        exp_inst    = w;
        if (exp_wen && w[11:7] != 5'd0)
            regs[w[11:7]] = res;  // x0 stays zero
    endtask

    // inputs and retire outputs are both settled at the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < `RV_NUM_REGS; k++) begin
                regs[k] = '0;
            end
            for (int k = 0; k < `RV_MEM_WORDS; k++) begin
                mem[k] = '0;
            end
            exp_valid = 1'b0;
            exp_inst  = '0;
            errors    = 0;
            checks    = 0;
        end else begin
            compare_retire();
            if (inst_valid)
                model_step(inst);
            else
                exp_valid = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_core_top.sv ====
`default_nettype none
`include "rv_core_config.svh"

module rv_core_top import rv_core_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   inst_valid,
    input  wire  [31:0]           inst,
    output logic                  retire_valid,
    output logic                  retire_wen,
    output logic [`RV_REG_AW-1:0] retire_rd,
    output logic [`RV_XLEN-1:0]   retire_data,
    output logic                  retire_illegal
);

    rf_if rf ();

    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   imm;
    logic                  use_imm;
    alu_op_e               alu_op;
    logic                  word_op;
    logic                  is_load;
    logic                  is_store;
    logic                  mem_dword;
    logic                  wb_en;
    logic                  dec_illegal;
    logic [`RV_XLEN-1:0]   alu_b;
    logic [`RV_XLEN-1:0]   alu_y;
    logic [`RV_XLEN-1:0]   mem_rdata;
    logic                  misaligned;
    logic                  illegal;
    logic [`RV_XLEN-1:0]   wb_data;
    logic [`RV_XLEN-1:0]   wb_final;

    inst_decode u_dec (
        .inst      (inst),
        .rs1       (rf.raddr1),
        .rs2       (rf.raddr2),
        .rd        (rd),
        .imm       (imm),
        .use_imm   (use_imm),
        .alu_op    (alu_op),
        .word_op   (word_op),
        .is_load   (is_load),
        .is_store  (is_store),
        .mem_dword (mem_dword),
        .wb_en     (wb_en),
        .illegal   (dec_illegal)
    );

    reg_file u_rf (
        .clk   (clk),
        .rst_n (rst_n),
        .rf    (rf.rf)
    );

    assign alu_b = use_imm ? imm : rf.rdata2;

    alu u_alu (
        .a       (rf.rdata1),
        .b       (alu_b),
        .op      (alu_op),
        .word_op (word_op),
        .y       (alu_y)
    );

    // address is rs1 + imm straight out of the alu
    data_mem u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (alu_y),
        .wdata      (rf.rdata2),
        .we         (inst_valid && is_store && !illegal),
        .dword      (mem_dword),
        .rdata      (mem_rdata),
        .misaligned (misaligned)
    );

    assign illegal  = dec_illegal || ((is_load || is_store) && misaligned);
    assign wb_data  = is_load ? mem_rdata : alu_y;
    assign wb_final = (rf.wmode == WM_WORD_SEXT) ?
                      {{(`RV_XLEN-32){wb_data[31]}}, wb_data[31:0]} : wb_data;

    assign rf.wen   = inst_valid && wb_en && !illegal;
    assign rf.waddr = rd;
    assign rf.wdata = wb_data;
    assign rf.wmode = (is_load && !mem_dword) ? WM_WORD_SEXT : WM_FULL;  // lw

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid   <= 1'b0;
            retire_wen     <= 1'b0;
            retire_illegal <= 1'b0;
        end else begin
            retire_valid   <= inst_valid;
            retire_wen     <= rf.wen;
            retire_illegal <= inst_valid && illegal;
        end
    end

    always_ff @(posedge clk) begin
        retire_rd   <= rd;
        retire_data <= wb_final;  // value as the register file stores it
    end

endmodule

`default_nettype wire

// ==== rtl/data_mem.sv ====
`default_nettype none
`include "rv_core_config.svh"

module data_mem (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire  [`RV_XLEN-1:0] addr,
    input  wire  [`RV_XLEN-1:0] wdata,
    input  wire                 we,
    input  wire                 dword,
    output logic [`RV_XLEN-1:0] rdata,
    output logic                misaligned
);

    logic [`RV_XLEN-1:0]   mem [0:`RV_MEM_WORDS-1];
    logic [`RV_MEM_AW-1:0] idx;
    logic [7:0]            be;
    logic [`RV_XLEN-1:0]   wpos;
    logic [`RV_XLEN-1:0]   line;

    assign idx        = addr[`RV_MEM_AW+2:3];  // doubleword index
    assign misaligned = dword ? (addr[2:0] != 3'b000) : (addr[1:0] != 2'b00);

    // word accesses pick a half by addr[2]
    assign be   = dword ? 8'hff : (addr[2] ? 8'hf0 : 8'h0f);
    assign wpos = dword ? wdata : {wdata[31:0], wdata[31:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `RV_MEM_WORDS; k++) begin
                mem[k] <= '0;
            end
        end else if (we) begin
            for (int b = 0; b < 8; b++) begin
                if (be[b])
                    mem[idx][b*8 +: 8] <= wpos[b*8 +: 8];
            end
        end
    end

    assign line = mem[idx];

    always_comb begin
        if (dword)
            rdata = line;
        else if (addr[2])
            rdata = {32'b0, line[63:32]};
        else
            rdata = {32'b0, line[31:0]};  // top sign-extends on writeback
    end

    // the core must squash misaligned stores before they get here
    a_no_misaligned_we: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> !misaligned);

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`default_nettype none
`include "rv_core_config.svh"

module alu import rv_core_pkg::*; (
    input  wire  [`RV_XLEN-1:0] a,
    input  wire  [`RV_XLEN-1:0] b,
    input  alu_op_e             op,
    input  wire                 word_op,
    output logic [`RV_XLEN-1:0] y
);

    logic [5:0]          shamt;
    logic [`RV_XLEN-1:0] a_op;
    logic [`RV_XLEN-1:0] res;

    assign shamt = word_op ? {1'b0, b[4:0]} : b[5:0];

    // word shifts see only the low half of a
    always_comb begin
        if (!word_op)
            a_op = a;
        else if (op == ALU_SRA)
            a_op = {{(`RV_XLEN-32){a[31]}}, a[31:0]};
        else
            a_op = {{(`RV_XLEN-32){1'b0}}, a[31:0]};
    end

    always_comb begin
        case (op)
            ALU_ADD:  res = a_op + b;
            ALU_SUB:  res = a_op - b;
            ALU_AND:  res = a_op & b;
            ALU_OR:   res = a_op | b;
            ALU_XOR:  res = a_op ^ b;
            ALU_SLL:  res = a_op << shamt;
            ALU_SRL:  res = a_op >> shamt;
            ALU_SRA:  res = $signed(a_op) >>> shamt;
            ALU_SLT:  res = {{(`RV_XLEN-1){1'b0}}, $signed(a_op) < $signed(b)};
            ALU_SLTU: res = {{(`RV_XLEN-1){1'b0}}, a_op < b};
            default:  res = '0;
        endcase
    end

    assign y = word_op ? {{(`RV_XLEN-32){res[31]}}, res[31:0]} : res;  // w forms sext

endmodule

`default_nettype wire

// ==== rtl/inst_decode.sv ====
`default_nettype none
`include "rv_core_config.svh"

module inst_decode import rv_core_pkg::*; (
    input  inst_u                 inst,
    output logic [`RV_REG_AW-1:0] rs1,
    output logic [`RV_REG_AW-1:0] rs2,
    output logic [`RV_REG_AW-1:0] rd,
    output logic [`RV_XLEN-1:0]   imm,
    output logic                  use_imm,
    output alu_op_e               alu_op,
    output logic                  word_op,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  mem_dword,
    output logic                  wb_en,
    output logic                  illegal
);

    // register fields sit at the same bits in every format
    assign rs1 = inst.r.rs1;
    assign rs2 = inst.r.rs2;
    assign rd  = inst.r.rd;

    assign imm = (inst.r.opcode == STORE) ?
                 {{(`RV_XLEN-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo} :
                 {{(`RV_XLEN-12){inst.i.imm12[11]}}, inst.i.imm12};

    always_comb begin
        use_imm   = 1'b0;
        alu_op    = ALU_ADD;
        word_op   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        mem_dword = 1'b0;
        wb_en     = 1'b0;
        illegal   = 1'b0;
        case (inst.r.opcode)
            OP: begin
                wb_en = 1'b1;
                case (inst.r.funct3)
                    3'b000: alu_op = inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001: alu_op = ALU_SLL;
                    3'b010: alu_op = ALU_SLT;
                    3'b011: alu_op = ALU_SLTU;
                    3'b100: alu_op = ALU_XOR;
                    3'b101: alu_op = inst.r.funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110: alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
                // alternate funct7 only for sub and sra
                illegal = !((inst.r.funct7 == 7'b0000000) ||
                            (inst.r.funct7 == 7'b0100000 &&
                             (inst.r.funct3 == 3'b000 || inst.r.funct3 == 3'b101)));
            end
            OP_IMM: begin
                wb_en   = 1'b1;
                use_imm = 1'b1;
                case (inst.i.funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    default: illegal = 1'b1;  // slti, shifts not supported
                endcase
            end
            OP_32: begin
                wb_en   = 1'b1;
                word_op = 1'b1;
                alu_op  = inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
                illegal = (inst.r.funct3 != 3'b000) ||
                          !(inst.r.funct7 == 7'b0000000 || inst.r.funct7 == 7'b0100000);
            end
            OP_IMM_32: begin
                wb_en   = 1'b1;
                word_op = 1'b1;
                use_imm = 1'b1;
                illegal = (inst.i.funct3 != 3'b000);  // addiw only
            end
            LOAD: begin
                wb_en     = 1'b1;
                use_imm   = 1'b1;
                is_load   = 1'b1;
                mem_dword = inst.i.funct3[0];
                illegal   = !(inst.i.funct3 == 3'b011 || inst.i.funct3 == 3'b010);
            end
            STORE: begin
                use_imm   = 1'b1;
                is_store  = 1'b1;
                mem_dword = inst.s.funct3[0];
                illegal   = !(inst.s.funct3 == 3'b011 || inst.s.funct3 == 3'b010);
            end
            default: illegal = 1'b1;
        endcase
        if (illegal) begin
            wb_en    = 1'b0;
            is_load  = 1'b0;
            is_store = 1'b0;
        end
    end

    always_comb begin
        a_ls_excl: assert (!(is_load && is_store));
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none
`include "rv_core_config.svh"

module reg_file import rv_core_pkg::*; (
    input  wire   clk,
    input  wire   rst_n,
    rf_if.rf      rf
);

    logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];  // no storage for x0
    logic [`RV_XLEN-1:0] wval;
    logic                wr_hit;

    // word mode keeps bit 31 as the sign
    assign wval = (rf.wmode == WM_WORD_SEXT) ?
                  {{(`RV_XLEN-32){rf.wdata[31]}}, rf.wdata[31:0]} : rf.wdata;
    assign wr_hit = rf.wen && (rf.waddr != '0);  // x0 writes dropped here

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 1; k < `RV_NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_hit) begin
            regs[rf.waddr] <= wval;
        end
    end

    always_comb begin
        if (rf.raddr1 == '0)
            rf.rdata1 = '0;
        else
            rf.rdata1 = regs[rf.raddr1];
    end

    always_comb begin
        if (rf.raddr2 == '0)
            rf.rdata2 = '0;
        else
            rf.rdata2 = regs[rf.raddr2];
    end

    // an x0 write must not land in the register being read
    a_x0_write_dropped: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rf.wen && rf.waddr == '0) && rf.raddr1 != '0 &&
         rf.raddr1 == $past(rf.raddr1)) |-> rf.rdata1 == $past(rf.rdata1));

    // x0 still reads zero right after someone tried to write it
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rf.wen && rf.waddr == '0) && rf.raddr1 == '0) |-> rf.rdata1 == '0);

endmodule

`default_nettype wire

// ==== rtl/rf_if.sv ====
`default_nettype none
`include "rv_core_config.svh"

interface rf_if import rv_core_pkg::*; ();
    logic [`RV_REG_AW-1:0] raddr1;
    logic [`RV_REG_AW-1:0] raddr2;
    logic [`RV_XLEN-1:0]   rdata1;
    logic [`RV_XLEN-1:0]   rdata2;
    logic                  wen;
    logic [`RV_REG_AW-1:0] waddr;
    logic [`RV_XLEN-1:0]   wdata;
    wmode_e                wmode;

    modport rf (
        input  raddr1, raddr2, wen, waddr, wdata, wmode,
        output rdata1, rdata2
    );

    modport user (
        output raddr1, raddr2, wen, waddr, wdata, wmode,
        input  rdata1, rdata2
    );
endinterface

`default_nettype wire

// ==== rtl/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s;

    // one instruction word, three ways to look at it
    typedef union packed {
        inst_r r;
        inst_i i;
        inst_s s;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic {
        WM_FULL,      // 64-bit value as is
        WM_WORD_SEXT  // low word, sign-extended
    } wmode_e;

    localparam logic [6:0] OP        = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_32     = 7'b0111011;
    localparam logic [6:0] OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] LOAD      = 7'b0000011;
    localparam logic [6:0] STORE     = 7'b0100011;

endpackage

`default_nettype wire

// ==== rtl/rv_core_config.svh ====
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// integer register width
`define RV_XLEN 64

// architectural register file
`define RV_NUM_REGS 32
`define RV_REG_AW 5

// data memory, counted in doublewords
`define RV_MEM_WORDS 64
`define RV_MEM_AW 6

`endif
